// File: Makefile
# Verilator build and run for the DAB modulator

VERILATOR ?= verilator
TOP       ?= dab_modulator_tb
FILELIST  ?= dab_modulator_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dab_modulator_top.f
+incdir+rtl
rtl/dab_pkg.sv
rtl/dab_pre_modulation_processor.sv
rtl/pwm_timebase_control.sv
rtl/pwm_channel.sv
rtl/pwm_output_stage.sv
rtl/dab_modulator_top.sv
tb/dab_modulator_assert.sv
tb/dab_modulator_tb.sv

// File: rtl/dab_modulator_top.sv
// DAB modulator top level
// Pre-modulation processor feeding the PWM timebase, four leg channels
// and the dead-time output stage

`timescale 1ns/1ns
`include "dab_params.svh"

module dab_modulator_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     configure,
    input  logic                     start,
    input  logic                     stop,
    input  logic                     update,
    input  logic [1:0]               modulation_type,
    input  dab_pkg::count_t          period,
    input  dab_pkg::count_t          duty,
    input  dab_pkg::count_t          phase_shift_1,
    input  dab_pkg::count_t          phase_shift_2,
    output logic                     done,
    output logic                     running,
    output logic [`DAB_CHANNELS-1:0] gate_high,
    output logic [`DAB_CHANNELS-1:0] gate_low
);

    import dab_pkg::*;

    pwm_write_t               write;
    count_t                   counter;
    count_t                   dead_time;
    edge_pair_t               edges [`DAB_CHANNELS];
    logic [`DAB_CHANNELS-1:0] enable_mask;
    logic [`DAB_CHANNELS-1:0] leg_level;

    dab_pre_modulation_processor i_dab_pre_modulation_processor (
        .clock          (clock),
        .reset          (reset),
        .configure      (configure),
        .start          (start),
        .stop           (stop),
        .update         (update),
        .modulation_type(modulation_type),
        .period         (period),
        .duty           (duty),
        .phase_shift_1  (phase_shift_1),
        .phase_shift_2  (phase_shift_2),
        .done           (done),
        .write          (write)
    );

    pwm_timebase_control i_pwm_timebase_control (
        .clock      (clock),
        .reset      (reset),
        .write      (write),
        .counter    (counter),
        .edges      (edges),
        .running    (running),
        .dead_time  (dead_time),
        .enable_mask(enable_mask)
    );

    for (genvar i = 0; i < `DAB_CHANNELS; i++) begin : g_channel
        pwm_channel i_pwm_channel (
            .clock    (clock),
            .reset    (reset),
            .counter  (counter),
            .edge_pair(edges[i]),
            .leg_level(leg_level[i])
        );
    end

    pwm_output_stage i_pwm_output_stage (
        .clock      (clock),
        .reset      (reset),
        .leg_level  (leg_level),
        .running    (running),
        .dead_time  (dead_time),
        .enable_mask(enable_mask),
        .gate_high  (gate_high),
        .gate_low   (gate_low)
    );

endmodule

// File: rtl/dab_params.svh
// DAB modulator parameters
// Channel count, widths, register map and configuration defaults
`ifndef DAB_PARAMS_SVH
`define DAB_PARAMS_SVH

`define DAB_CHANNELS          4
`define DAB_COUNT_WIDTH       16
`define DAB_ADDR_WIDTH        12
`define DAB_DATA_WIDTH        32

`define DAB_CTRL_ADDR         12'h000
`define DAB_EDGE_BASE_ADDR    12'h100
`define DAB_PERIOD_ADDR       12'h134
`define DAB_DEAD_TIME_ADDR    12'h13C
`define DAB_ENABLE_ADDR       12'h144

`define DAB_DEFAULT_DEAD_TIME 16'd3
`define DAB_DEFAULT_ENABLE    4'hF

`define DAB_MOD_SPS           2'd0
`define DAB_MOD_DPS           2'd1

`endif

// File: rtl/dab_pkg.sv
// DAB modulator types
// Counter, register and write types shared by the modulator blocks

`include "dab_params.svh"

package dab_pkg;

    typedef logic [`DAB_COUNT_WIDTH-1:0] count_t;
    typedef logic [`DAB_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [`DAB_DATA_WIDTH-1:0]  reg_data_t;

    // One register write, valid for a single cycle
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
        logic      valid;
    } pwm_write_t;

    // Turn-on and turn-off counts of one bridge leg
    typedef struct packed {
        count_t on;
        count_t off;
    } edge_pair_t;

    typedef enum logic [2:0] {
        state_idle,
        state_configure,
        state_calculate,
        state_update,
        state_gap
    } processor_state_t;

endpackage

// File: rtl/dab_pre_modulation_processor.sv
// DAB pre-modulation processor
// Computes SPS or DPS edge counts for the four bridge legs and
// sequences the configuration, update, start and stop register writes

`timescale 1ns/1ns
`include "dab_params.svh"

module dab_pre_modulation_processor (
    input  logic                clock,
    input  logic                reset,
    input  logic                configure,
    input  logic                start,
    input  logic                stop,
    input  logic                update,
    input  logic [1:0]          modulation_type,
    input  dab_pkg::count_t     period,
    input  dab_pkg::count_t     duty,
    input  dab_pkg::count_t     phase_shift_1,
    input  dab_pkg::count_t     phase_shift_2,
    output logic                done,
    output dab_pkg::pwm_write_t write
);

    import dab_pkg::*;

    localparam int config_last = 2;
    localparam int update_last = 2 * `DAB_CHANNELS;

    processor_state_t state;
    processor_state_t resume_state;
    logic [3:0]       write_index;
    logic             update_pending;
    logic             run_state;

    edge_pair_t edge_set [`DAB_CHANNELS];
    edge_pair_t update_pair;
    count_t     period_set;
    count_t     leg_shift [`DAB_CHANNELS];
    count_t     base_on;
    count_t     base_off;
    logic       dps;

    reg_addr_t config_addr;
    reg_data_t config_data;
    reg_addr_t update_addr;
    reg_data_t update_data;

    assign dps      = (modulation_type == `DAB_MOD_DPS);
    assign base_on  = (period >> 1) - (duty >> 1);
    assign base_off = (period >> 1) + (duty >> 1);

    // Leg order is primary A, primary B, secondary A, secondary B
    always_comb begin
        leg_shift[0] = '0;
        leg_shift[1] = dps ? (phase_shift_2 >> 1) : '0;
        leg_shift[2] = phase_shift_1 >> 1;
        leg_shift[3] = (phase_shift_1 >> 1) + leg_shift[1];
    end

    always_ff @(posedge clock) begin
        if (state == state_calculate) begin
            period_set <= period;
            for (int i = 0; i < `DAB_CHANNELS; i++) begin
                edge_set[i].on  <= base_on + leg_shift[i];
                edge_set[i].off <= base_off + leg_shift[i];
            end
        end
    end

    always_comb begin
        case (write_index[1:0])
            2'd0: begin
                config_addr = `DAB_DEAD_TIME_ADDR;
                config_data = reg_data_t'(`DAB_DEFAULT_DEAD_TIME);
            end
            2'd1: begin
                config_addr = `DAB_ENABLE_ADDR;
                config_data = reg_data_t'(`DAB_DEFAULT_ENABLE);
            end
            default: begin
                config_addr = `DAB_CTRL_ADDR;
                config_data = '0;
            end
        endcase
    end

    // Indices 0 to 3 are the on registers, 4 to 7 the off registers, 8 the period
    always_comb begin
        update_pair = edge_set[write_index[1:0]];
        if (write_index == 4'(update_last)) begin
            update_addr = `DAB_PERIOD_ADDR;
            update_data = reg_data_t'(period_set);
        end else begin
            update_addr = `DAB_EDGE_BASE_ADDR + reg_addr_t'({write_index, 2'b00});
            update_data = reg_data_t'(write_index[2] ? update_pair.off : update_pair.on);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state          <= state_idle;
            resume_state   <= state_idle;
            write_index    <= '0;
            update_pending <= 1'b0;
            run_state      <= 1'b0;
            done           <= 1'b0;
            write          <= '0;
        end else begin
            done        <= 1'b0;
            write.valid <= 1'b0;
            case (state)
                state_idle: begin
                    if (configure) begin
                        write_index <= '0;
                        run_state   <= 1'b0;
                        state       <= state_configure;
                    end else if (start || stop) begin
                        run_state    <= start;
                        write        <= '{addr: `DAB_CTRL_ADDR,
                                          data: reg_data_t'(start),
                                          valid: 1'b1};
                        resume_state <= state_idle;
                        state        <= state_gap;
                    end else if (update_pending && !run_state) begin
                        update_pending <= 1'b0;
                        if (modulation_type == `DAB_MOD_SPS || dps) begin
                            state <= state_calculate;
                        end
                    end
                end
                state_calculate: begin
                    write_index <= '0;
                    state       <= state_update;
                end
                state_configure: begin
                    write       <= '{addr: config_addr, data: config_data, valid: 1'b1};
                    write_index <= write_index + 4'd1;
                    state       <= state_gap;
                    if (write_index == 4'(config_last)) begin
                        done         <= 1'b1;
                        resume_state <= state_idle;
                    end else begin
                        resume_state <= state_configure;
                    end
                end
                state_update: begin
                    write       <= '{addr: update_addr, data: update_data, valid: 1'b1};
                    write_index <= write_index + 4'd1;
                    state       <= state_gap;
                    if (write_index == 4'(update_last)) begin
                        done         <= 1'b1;
                        resume_state <= state_idle;
                    end else begin
                        resume_state <= state_update;
                    end
                end
                state_gap: begin
                    state <= resume_state;
                end
                default: begin
                    state <= state_idle;
                end
            endcase
            // A new request is kept even while a sequence is running
            if (update) begin
                update_pending <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/pwm_channel.sv
// PWM channel
// Registered window comparison that drives one bridge leg's raw level

`timescale 1ns/1ns

module pwm_channel (
    input  logic                clock,
    input  logic                reset,
    input  dab_pkg::count_t     counter,
    input  dab_pkg::edge_pair_t edge_pair,
    output logic                leg_level
);

    // High from the on count up to, but not including, the off count
    always_ff @(posedge clock) begin
        if (!reset) begin
            leg_level <= 1'b0;
        end else begin
            leg_level <= (counter >= edge_pair.on) && (counter < edge_pair.off);
        end
    end

endmodule

// File: rtl/pwm_output_stage.sv
// PWM output stage
// Inserts dead time on every leg and drives complementary high-side and
// low-side gates, gated by the run state and the leg output mask

`timescale 1ns/1ns
`include "dab_params.svh"

module pwm_output_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [`DAB_CHANNELS-1:0] leg_level,
    input  logic                     running,
    input  dab_pkg::count_t          dead_time,
    input  logic [`DAB_CHANNELS-1:0] enable_mask,
    output logic [`DAB_CHANNELS-1:0] gate_high,
    output logic [`DAB_CHANNELS-1:0] gate_low
);

    import dab_pkg::*;

    logic [`DAB_CHANNELS-1:0] level_q;
    logic [`DAB_CHANNELS-1:0] settled;
    count_t                   dwell [`DAB_CHANNELS];

    // Dwell counts the cycles since the last level change and saturates at dead_time
    always_ff @(posedge clock) begin
        if (!reset) begin
            level_q <= '0;
            for (int i = 0; i < `DAB_CHANNELS; i++) begin
                dwell[i] <= '0;
            end
        end else begin
            level_q <= leg_level;
            for (int i = 0; i < `DAB_CHANNELS; i++) begin
                if (leg_level[i] != level_q[i]) begin
                    dwell[i] <= '0;
                end else if (dwell[i] < dead_time) begin
                    dwell[i] <= dwell[i] + count_t'(1);
                end
            end
        end
    end

    // Only one gate of a leg follows level_q, so the pair never overlaps
    always_comb begin
        for (int i = 0; i < `DAB_CHANNELS; i++) begin
            settled[i]   = running && enable_mask[i] && (dwell[i] >= dead_time);
            gate_high[i] = settled[i] && level_q[i];
            gate_low[i]  = settled[i] && !level_q[i];
        end
    end

endmodule

// File: rtl/pwm_timebase_control.sv
// PWM timebase and register block
// Decodes register writes into shadow registers, copies them to the
// active set at the counter wrap and runs the shared period counter

`timescale 1ns/1ns
`include "dab_params.svh"

module pwm_timebase_control (
    input  logic                     clock,
    input  logic                     reset,
    input  dab_pkg::pwm_write_t      write,
    output dab_pkg::count_t          counter,
    output dab_pkg::edge_pair_t      edges [`DAB_CHANNELS],
    output logic                     running,
    output dab_pkg::count_t          dead_time,
    output logic [`DAB_CHANNELS-1:0] enable_mask
);

    import dab_pkg::*;

    edge_pair_t shadow_edges [`DAB_CHANNELS];
    count_t     shadow_period;
    count_t     active_period;
    logic       wrap;
    logic       load_active;

    assign wrap        = running && (counter >= active_period - count_t'(1));
    assign load_active = !running || wrap;

    always_ff @(posedge clock) begin
        if (!reset) begin
            running       <= 1'b0;
            dead_time     <= `DAB_DEFAULT_DEAD_TIME;
            enable_mask   <= `DAB_DEFAULT_ENABLE;
            shadow_period <= '0;
            for (int i = 0; i < `DAB_CHANNELS; i++) begin
                shadow_edges[i] <= '0;
            end
        end else if (write.valid) begin
            case (write.addr)
                `DAB_CTRL_ADDR:      running       <= write.data[0];
                `DAB_PERIOD_ADDR:    shadow_period <= write.data[`DAB_COUNT_WIDTH-1:0];
                `DAB_DEAD_TIME_ADDR: dead_time     <= write.data[`DAB_COUNT_WIDTH-1:0];
                `DAB_ENABLE_ADDR:    enable_mask   <= write.data[`DAB_CHANNELS-1:0];
                default: ;
            endcase
            // All on registers come first, then all off registers
            for (int i = 0; i < `DAB_CHANNELS; i++) begin
                if (write.addr == reg_addr_t'(`DAB_EDGE_BASE_ADDR + 4 * i)) begin
                    shadow_edges[i].on <= write.data[`DAB_COUNT_WIDTH-1:0];
                end
                if (write.addr == reg_addr_t'(`DAB_EDGE_BASE_ADDR + 4 * (`DAB_CHANNELS + i))) begin
                    shadow_edges[i].off <= write.data[`DAB_COUNT_WIDTH-1:0];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter       <= '0;
            active_period <= '0;
            for (int i = 0; i < `DAB_CHANNELS; i++) begin
                edges[i] <= '0;
            end
        end else begin
            if (load_active) begin
                counter <= '0;
            end else begin
                counter <= counter + count_t'(1);
            end
            // While stopped the active set simply follows the shadow set
            if (load_active) begin
                active_period <= shadow_period;
                edges         <= shadow_edges;
            end
        end
    end

endmodule

// File: tb/dab_modulator_assert.sv
// DAB modulator assertions
// Concurrent checks on gate overlap, dead time, the done pulse and
// the run state at the top-level ports

`timescale 1ns/1ns
`include "dab_params.svh"

module dab_modulator_assert (
    input logic                     clock,
    input logic                     reset,
    input logic                     start,
    input logic                     stop,
    input logic                     done,
    input logic                     running,
    input logic [`DAB_CHANNELS-1:0] gate_high,
    input logic [`DAB_CHANNELS-1:0] gate_low
);

    int                       assert_errors = 0;
    logic [`DAB_CHANNELS-1:0] pair_idle;

    assign pair_idle = ~(gate_high | gate_low);

    a_no_overlap: assert property (@(posedge clock) disable iff (!reset)
        (gate_high & gate_low) == '0)
        else begin
            assert_errors++;
            $error("High and low gates of a leg are on together, high %b low %b",
                   gate_high, gate_low);
        end

    a_stopped_gates_low: assert property (@(posedge clock) disable iff (!reset)
        !running |-> (gate_high == '0 && gate_low == '0))
        else begin
            assert_errors++;
            $error("A gate is on while the modulator is stopped");
        end

    // Either gate of a leg may only turn on after the pair was idle for the dead time
    for (genvar i = 0; i < `DAB_CHANNELS; i++) begin : g_dead_time
        a_dead_time: assert property (@(posedge clock) disable iff (!reset)
            ($rose(gate_high[i]) || $rose(gate_low[i])) |->
                $past(pair_idle[i], 1) && $past(pair_idle[i], 2) && $past(pair_idle[i], 3))
            else begin
                assert_errors++;
                $error("Leg %0d turned a gate on with less than %0d idle cycles",
                       i, `DAB_DEFAULT_DEAD_TIME);
            end
    end

    a_done_pulse: assert property (@(posedge clock) disable iff (!reset)
        done |=> !done)
        else begin
            assert_errors++;
            $error("Done stayed high for more than one cycle");
        end

    a_start_runs: assert property (@(posedge clock) disable iff (!reset)
        $past(start, 2) |-> running)
        else begin
            assert_errors++;
            $error("Running did not rise after a start strobe");
        end

    a_stop_halts: assert property (@(posedge clock) disable iff (!reset)
        $past(stop, 2) |-> !running)
        else begin
            assert_errors++;
            $error("Running did not fall after a stop strobe");
        end

endmodule

bind dab_modulator_top dab_modulator_assert i_dab_modulator_assert (
    .clock    (clock),
    .reset    (reset),
    .start    (start),
    .stop     (stop),
    .done     (done),
    .running  (running),
    .gate_high(gate_high),
    .gate_low (gate_low)
);

// File: tb/dab_modulator_tb.sv
// DAB modulator testbench
// Runs configure, SPS and DPS update, start and stop sequences and checks
// done counts, leg equality and phase spacing of the gate outputs

`timescale 1ns/1ns
`include "dab_params.svh"

module dab_modulator_tb;

    import dab_pkg::*;

    localparam int clock_period     = 40;
    localparam int pwm_period       = 40;
    localparam int timeout_cycles   = 12 * pwm_period + 100;
    localparam int strobe_configure = 0;
    localparam int strobe_start     = 1;
    localparam int strobe_stop      = 2;
    localparam int strobe_update    = 3;

    logic                     clock;
    logic                     reset;
    logic                     configure;
    logic                     start;
    logic                     stop;
    logic                     update;
    logic [1:0]               modulation_type;
    count_t                   period;
    count_t                   duty;
    count_t                   phase_shift_1;
    count_t                   phase_shift_2;
    logic                     done;
    logic                     running;
    logic [`DAB_CHANNELS-1:0] gate_high;
    logic [`DAB_CHANNELS-1:0] gate_low;

    int                       sequence_errors = 0;
    int                       monitor_errors = 0;
    int                       cycle_count = 0;
    int                       done_count = 0;
    logic [31:0]              random_state;
    logic                     run_checks;
    int                       expected_shift_1;
    int                       expected_shift_2;
    int                       rise_cycle [`DAB_CHANNELS];
    logic [`DAB_CHANNELS-1:0] rise_seen = '0;
    logic [`DAB_CHANNELS-1:0] rose;
    logic [`DAB_CHANNELS-1:0] high_q = '0;

    dab_modulator_top i_dab_modulator_top (
        .clock          (clock),
        .reset          (reset),
        .configure      (configure),
        .start          (start),
        .stop           (stop),
        .update         (update),
        .modulation_type(modulation_type),
        .period         (period),
        .duty           (duty),
        .phase_shift_1  (phase_shift_1),
        .phase_shift_2  (phase_shift_2),
        .done           (done),
        .running        (running),
        .gate_high      (gate_high),
        .gate_low       (gate_low)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input int actual, input int expected);
        $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
    endtask

    task automatic pulse_strobe(input int which);
        @(posedge clock);
        #5;
        configure = (which == strobe_configure);
        start     = (which == strobe_start);
        stop      = (which == strobe_stop);
        update    = (which == strobe_update);
        @(posedge clock);
        #5;
        configure = 1'b0;
        start     = 1'b0;
        stop      = 1'b0;
        update    = 1'b0;
    endtask

    // Done must pulse once for the request and stay quiet afterwards
    task automatic request_and_check_done(input int which);
        int count_before;
        count_before = done_count;
        pulse_strobe(which);
        while (!done) @(negedge clock);
        repeat (4) @(posedge clock);
        #5;
        assert (done_count == count_before + 1) else begin
            sequence_errors++;
            report_mismatch("done pulse count", done_count - count_before, 1);
        end
    endtask

    task automatic run_mode(input logic [1:0] mode);
        @(posedge clock);
        #5;
        // Duty 10..20 and shifts 2..9 keep every edge below the period
        random_state     = xorshift32(random_state);
        duty             = count_t'(10 + random_state % 11);
        random_state     = xorshift32(random_state);
        phase_shift_1    = count_t'(2 + random_state % 8);
        random_state     = xorshift32(random_state);
        phase_shift_2    = count_t'(2 + random_state % 8);
        modulation_type  = mode;
        expected_shift_1 = int'(phase_shift_1 >> 1);
        expected_shift_2 = int'(phase_shift_2 >> 1);
        request_and_check_done(strobe_update);
        pulse_strobe(strobe_start);
        while (!running) @(negedge clock);
        run_checks = 1'b1;
        repeat (3 * pwm_period) @(posedge clock);
        // Every leg switches its high gate on at least once per period
        assert (rise_seen == '1) else begin
            sequence_errors++;
            report_mismatch("legs with a rising high gate", int'(rise_seen),
                            (1 << `DAB_CHANNELS) - 1);
        end
        run_checks = 1'b0;
        pulse_strobe(strobe_stop);
        while (running) @(negedge clock);
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("sim failed");
            $finish;
        end
    end

    always @(negedge clock) begin
        if (done) begin
            done_count++;
        end
    end

    // Gate relations and rising-edge spacing while a run is checked
    always @(negedge clock) begin
        rose = gate_high & ~high_q;
        if (!run_checks) begin
            rise_seen = '0;
        end else begin
            for (int i = 0; i < `DAB_CHANNELS; i++) begin
                if (rose[i]) begin
                    rise_cycle[i] = cycle_count;
                    rise_seen[i]  = 1'b1;
                end
            end
            if (modulation_type == `DAB_MOD_SPS) begin
                assert ({gate_high[1], gate_low[1]} == {gate_high[0], gate_low[0]}) else begin
                    monitor_errors++;
                    report_mismatch("primary B gate pair", int'({gate_high[1], gate_low[1]}),
                                    int'({gate_high[0], gate_low[0]}));
                end
                assert ({gate_high[3], gate_low[3]} == {gate_high[2], gate_low[2]}) else begin
                    monitor_errors++;
                    report_mismatch("secondary B gate pair", int'({gate_high[3], gate_low[3]}),
                                    int'({gate_high[2], gate_low[2]}));
                end
                if (rose[2] && rise_seen[0]) begin
                    assert (rise_cycle[2] - rise_cycle[0] == expected_shift_1) else begin
                        monitor_errors++;
                        report_mismatch("secondary A rise delay",
                                        rise_cycle[2] - rise_cycle[0], expected_shift_1);
                    end
                end
            end else begin
                if (rose[1] && rise_seen[0]) begin
                    assert (rise_cycle[1] - rise_cycle[0] == expected_shift_2) else begin
                        monitor_errors++;
                        report_mismatch("primary B rise delay",
                                        rise_cycle[1] - rise_cycle[0], expected_shift_2);
                    end
                end
                if (rose[3] && rise_seen[2]) begin
                    assert (rise_cycle[3] - rise_cycle[2] == expected_shift_2) else begin
                        monitor_errors++;
                        report_mismatch("secondary B rise delay",
                                        rise_cycle[3] - rise_cycle[2], expected_shift_2);
                    end
                end
            end
        end
        high_q = gate_high;
    end

    initial begin
        reset            = 1'b0;
        configure        = 1'b0;
        start            = 1'b0;
        stop             = 1'b0;
        update           = 1'b0;
        modulation_type  = `DAB_MOD_SPS;
        period           = count_t'(pwm_period);
        duty             = '0;
        phase_shift_1    = '0;
        phase_shift_2    = '0;
        random_state     = 32'd4505;
        run_checks       = 1'b0;
        expected_shift_1 = 0;
        expected_shift_2 = 0;
        repeat (3) @(posedge clock);
        #5;
        reset = 1'b1;
        request_and_check_done(strobe_configure);
        run_mode(`DAB_MOD_SPS);
        run_mode(`DAB_MOD_DPS);
        repeat (4) @(posedge clock);
        $display("Errors: sequence %0d, monitor %0d, assertions %0d", sequence_errors,
                 monitor_errors, i_dab_modulator_top.i_dab_modulator_assert.assert_errors);
        if (sequence_errors + monitor_errors
            + i_dab_modulator_top.i_dab_modulator_assert.assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
